// File: hdl/membridge_macros.svh
`ifndef MEMBRIDGE_MACROS_SVH
`define MEMBRIDGE_MACROS_SVH

// register offsets
`define MB_REG_CTRL      4'd0
`define MB_REG_LO_ADDR   4'd2
`define MB_REG_SIZE      4'd3
`define MB_REG_START     4'd4
`define MB_REG_LEN       4'd5

`define MB_ADDR64_W      29   // 64-bit word address bits

`define MB_BURST_MAX     16   // beats per full burst

// line buffer geometry
`define MB_PAGE_WORDS    128
`define MB_PAGES         4

// port FIFO fill levels that block new work
`define MB_WACOUNT_SAFE  12
`define MB_WCOUNT_SAFE   120

`endif

// File: hdl/membridge_cfg_pkg.sv
`include "membridge_macros.svh"

package membridge_cfg_pkg;

    typedef logic [`MB_ADDR64_W-1:0] addr64_t; // word address or word count

    // writable registers
    typedef enum logic [3:0] {
        REG_CTRL    = `MB_REG_CTRL,
        REG_LO_ADDR = `MB_REG_LO_ADDR,
        REG_SIZE    = `MB_REG_SIZE,
        REG_START   = `MB_REG_START,
        REG_LEN     = `MB_REG_LEN
    } reg_sel_e;

    // window and transfer setup seen by the datapath
    typedef struct packed {
        addr64_t lo_addr;    // window base
        addr64_t size;       // window size, rollover point
        addr64_t start;      // first address relative to lo
        addr64_t len;        // transfer length in words
        logic    en;         // channel enable
        logic    reset_addr; // start reloads the address
    } cfg_t;

endpackage

// File: hdl/membridge_axi_pkg.sv
package membridge_axi_pkg;

    typedef logic [31:0] axi_addr_t;  // byte address
    typedef logic [3:0]  burst_len_t; // beats minus one
    typedef logic [5:0]  axi_id_t;
    typedef logic [63:0] wdata_t;

    // write address channel payload
    typedef struct packed {
        axi_addr_t  addr;
        burst_len_t len;
        axi_id_t    id;
    } aw_req_t;

    // burst generator states
    typedef enum logic [1:0] {
        GEN_IDLE,  // waiting for start
        GEN_ISSUE, // bursts still to issue
        GEN_DRAIN, // waiting for data and responses
        GEN_DONE
    } gen_state_e;

endpackage

// File: hdl/membridge_regs.sv
`timescale 1ns/10ps
`include "membridge_macros.svh"

module membridge_regs (
    input  logic                        hclk,
    input  logic                        rst,
    input  logic                        reg_we_i,
    input  membridge_cfg_pkg::reg_sel_e reg_addr_i,
    input  logic [31:0]                 reg_data_i,
    output membridge_cfg_pkg::cfg_t     cfg_o,
    output logic                        start_o
);
    localparam int BW = $clog2(`MB_BURST_MAX); // low bits cleared by alignment

    membridge_cfg_pkg::addr64_t lo_addr;
    membridge_cfg_pkg::addr64_t size;
    membridge_cfg_pkg::addr64_t start_addr;
    membridge_cfg_pkg::addr64_t len;
    membridge_cfg_pkg::addr64_t aligned;     // write data on a 16-word boundary
    logic                       en;
    logic                       reset_addr;
    logic                       set_ctrl;

    assign aligned  = {reg_data_i[`MB_ADDR64_W-1:BW], BW'(0)};
    assign set_ctrl = reg_we_i && (reg_addr_i == membridge_cfg_pkg::REG_CTRL);

    always_ff @(posedge hclk) begin
        if (reg_we_i) begin
            case (reg_addr_i)
                membridge_cfg_pkg::REG_LO_ADDR: begin
                    lo_addr    <= aligned;
                    start_addr <= '0;           // new window restarts at its base
                end
                membridge_cfg_pkg::REG_SIZE:  size       <= aligned;
                membridge_cfg_pkg::REG_START: start_addr <= aligned;
                membridge_cfg_pkg::REG_LEN:   len        <= reg_data_i[`MB_ADDR64_W-1:0]; // any length
                membridge_cfg_pkg::REG_CTRL:  reset_addr <= reg_data_i[1] && !reg_data_i[2];
                default: ;
            endcase
        end
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            en      <= 1'b0;
            start_o <= 1'b0;
        end else begin
            if (set_ctrl) begin
                en <= reg_data_i[0];
            end
            start_o <= set_ctrl && reg_data_i[1]; // one cycle after the ctrl write
        end
    end

    assign cfg_o.lo_addr    = lo_addr;
    assign cfg_o.size       = size;
    assign cfg_o.start      = start_addr;
    assign cfg_o.len        = len;
    assign cfg_o.en         = en;
    assign cfg_o.reset_addr = reset_addr;

endmodule

// File: hdl/membridge_burst_gen.sv
`timescale 1ns/10ps
`include "membridge_macros.svh"

module membridge_burst_gen (
    input  logic                       hclk,
    input  logic                       rst,
    input  membridge_cfg_pkg::cfg_t    cfg_i,
    input  logic                       start_i,
    input  logic [5:0]                 afi_wacount_i,
    input  logic                       afi_bvalid_i,
    output membridge_axi_pkg::aw_req_t aw_o,
    output logic                       awvalid_o,
    input  logic                       words_sent_i,
    output logic                       busy_o,
    output logic                       done_o
);
    localparam int SETTLE = 3;                      // cycles for the adders after a change
    localparam int BW     = $clog2(`MB_BURST_MAX);
    localparam int BLK_W  = `MB_ADDR64_W - BW;      // 16-word block number bits

    membridge_axi_pkg::gen_state_e state;
    membridge_cfg_pkg::addr64_t    rel_addr;        // relative to lo
    membridge_cfg_pkg::addr64_t    left;            // words not yet covered by a burst
    membridge_cfg_pkg::addr64_t    axi_addr64;
    logic [BLK_W-1:0]              last_blk;        // block before rollover
    membridge_axi_pkg::burst_len_t len_q;
    membridge_axi_pkg::axi_id_t    wr_id;
    logic [SETTLE-1:0]             settle_d;
    logic                          advance;         // burst issued this cycle
    logic                          last_burst;      // fewer than 16 words left
    logic                          rollover;
    logic                          words_done;
    logic [7:0]                    n_issued;
    logic [7:0]                    n_resp;
    logic                          issue_ok;

    assign issue_ok = (state == membridge_axi_pkg::GEN_ISSUE) && cfg_i.en &&
                      (afi_wacount_i < 6'(`MB_WACOUNT_SAFE)) && (|left) &&
                      !advance && (settle_d == '0);

    // address and length datapath
    always_ff @(posedge hclk) begin
        last_blk   <= cfg_i.size[`MB_ADDR64_W-1:BW] - BLK_W'(1);
        last_burst <= ~|left[`MB_ADDR64_W-1:BW];
        rollover   <= rel_addr[`MB_ADDR64_W-1:BW] == last_blk;
        len_q      <= (|left[`MB_ADDR64_W-1:BW]) ? '1 : left[BW-1:0] - BW'(1);
        axi_addr64 <= cfg_i.lo_addr + rel_addr;
        if (start_i && cfg_i.reset_addr) begin
            rel_addr <= cfg_i.start;            // continue keeps the old address
        end else if (advance) begin
            if (last_burst) begin
                rel_addr <= rel_addr + membridge_cfg_pkg::addr64_t'(left[BW-1:0]);
            end else if (rollover) begin
                rel_addr <= '0;                 // wrap to window base
            end else begin
                rel_addr <= rel_addr + membridge_cfg_pkg::addr64_t'(`MB_BURST_MAX);
            end
        end
        if (start_i) begin
            left <= cfg_i.len;
        end else if (advance) begin
            left <= last_burst ? '0 : left - membridge_cfg_pkg::addr64_t'(`MB_BURST_MAX);
        end
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            state      <= membridge_axi_pkg::GEN_IDLE;
            settle_d   <= '0;
            advance    <= 1'b0;
            wr_id      <= '0;
            n_issued   <= '0;
            n_resp     <= '0;
            words_done <= 1'b0;
        end else begin
            settle_d <= {settle_d[SETTLE-2:0], advance | start_i};
            advance  <= issue_ok;
            if (start_i) begin
                wr_id      <= wr_id + 1'b1;     // new ID per transfer
                n_issued   <= '0;
                n_resp     <= '0;
                words_done <= 1'b0;
            end else begin
                if (advance)      n_issued   <= n_issued + 1'b1;
                if (afi_bvalid_i) n_resp     <= n_resp + 1'b1;
                if (words_sent_i) words_done <= 1'b1;
            end
            if (start_i) begin
                state <= membridge_axi_pkg::GEN_ISSUE;
            end else begin
                case (state)
                    membridge_axi_pkg::GEN_ISSUE:
                        if ((settle_d == '0) && !advance && (left == '0))
                            state <= membridge_axi_pkg::GEN_DRAIN;
                    membridge_axi_pkg::GEN_DRAIN:
                        if (words_done && (n_issued == n_resp))
                            state <= membridge_axi_pkg::GEN_DONE;
                    membridge_axi_pkg::GEN_DONE:
                        if (!cfg_i.en) state <= membridge_axi_pkg::GEN_IDLE;
                    default: ;
                endcase
            end
        end
    end

    assign aw_o.addr = {axi_addr64, 3'b000}; // word to byte address
    assign aw_o.len  = len_q;
    assign aw_o.id   = wr_id;
    assign awvalid_o = advance;
    assign busy_o    = (state == membridge_axi_pkg::GEN_ISSUE) ||
                       (state == membridge_axi_pkg::GEN_DRAIN);
    assign done_o    = state == membridge_axi_pkg::GEN_DONE;

endmodule

// File: hdl/membridge_page_buf.sv
`timescale 1ns/10ps
`include "membridge_macros.svh"

module membridge_page_buf (
    input  logic                      hclk,
    input  logic                      rst,
    input  logic                      start_i,
    input  logic                      buf_wr_i,
    input  membridge_axi_pkg::wdata_t buf_wdata_i,
    input  logic                      buf_wpage_nxt_i,
    input  logic                      page_ready_i,
    input  logic                      rd_i,
    input  logic [6:0]                rd_addr_i,
    output membridge_axi_pkg::wdata_t rd_data_o,
    input  logic                      page_done_i,
    output logic [2:0]                pages_avail_o,
    output logic                      next_page_o
);
    localparam int IDX_W = $clog2(`MB_PAGE_WORDS);
    localparam int PG_W  = $clog2(`MB_PAGES);

    membridge_axi_pkg::wdata_t mem [`MB_PAGES*`MB_PAGE_WORDS];
    membridge_axi_pkg::wdata_t rd_q;   // first read stage
    logic [PG_W-1:0]           wpage;  // page being filled
    logic [IDX_W-1:0]          widx;
    logic [PG_W-1:0]           rpage;  // page being drained
    logic                      rd_d;

    always_ff @(posedge hclk) begin
        if (buf_wr_i) begin
            mem[{wpage, widx}] <= buf_wdata_i;
        end
        if (rd_i) begin
            rd_q <= mem[{rpage, rd_addr_i}];
        end
        if (rd_d) begin
            rd_data_o <= rd_q;          // valid two cycles after rd
        end
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            wpage         <= '0;
            widx          <= '0;
            rpage         <= '0;
            rd_d          <= 1'b0;
            pages_avail_o <= '0;
            next_page_o   <= 1'b0;
        end else begin
            rd_d        <= rd_i;
            next_page_o <= page_done_i; // release to the memory controller
            if (start_i) begin
                wpage <= '0;
                widx  <= '0;
            end else if (buf_wpage_nxt_i) begin
                wpage <= wpage + 1'b1;
                widx  <= '0;
            end else if (buf_wr_i) begin
                widx <= widx + 1'b1;
            end
            if (start_i) begin
                rpage <= '0;
            end else if (page_done_i) begin
                rpage <= rpage + 1'b1;
            end
            // filled pages not yet drained
            if (start_i) begin
                pages_avail_o <= '0;
            end else if (page_ready_i && !page_done_i) begin
                pages_avail_o <= pages_avail_o + 1'b1;
            end else if (!page_ready_i && page_done_i) begin
                pages_avail_o <= pages_avail_o - 1'b1;
            end
        end
    end

endmodule

// File: hdl/membridge_wdata.sv
`timescale 1ns/10ps
`include "membridge_macros.svh"

module membridge_wdata (
    input  logic                       hclk,
    input  logic                       rst,
    input  membridge_cfg_pkg::cfg_t    cfg_i,
    input  logic                       start_i,
    input  logic [2:0]                 pages_avail_i,
    input  logic [7:0]                 afi_wcount_i,
    output logic                       rd_o,
    output logic [6:0]                 rd_addr_o,
    input  membridge_axi_pkg::wdata_t  rd_data_i,
    output logic                       page_done_o,
    output membridge_axi_pkg::wdata_t  afi_wdata_o,
    output logic                       afi_wvalid_o,
    output logic                       afi_wlast_o,
    output membridge_axi_pkg::axi_id_t afi_wid_o,
    output logic                       last_word_o
);
    localparam int IDX_W  = $clog2(`MB_PAGE_WORDS);
    localparam int BEAT_W = $clog2(`MB_BURST_MAX);

    membridge_cfg_pkg::addr64_t left;     // words not yet read
    logic [IDX_W-1:0]           idx;      // word in page
    logic [BEAT_W-1:0]          beat;     // beat in burst
    logic                       rd_q;
    logic                       final_w;  // reading the final word
    logic                       last_w;
    logic                       can_read;
    logic [2:0]                 pipe_d1;  // {final, wlast, valid}
    logic [2:0]                 pipe_d2;
    membridge_axi_pkg::axi_id_t wr_id;

    assign final_w     = left == membridge_cfg_pkg::addr64_t'(1);
    assign last_w      = (&beat) || final_w;
    assign page_done_o = rd_q && ((&idx) || final_w);

    // pages_avail drops a cycle late so discount a page finishing now
    assign can_read = cfg_i.en && (|left) && !(rd_q && final_w) &&
                      (afi_wcount_i < 8'(`MB_WCOUNT_SAFE)) &&
                      (pages_avail_i > {2'b00, page_done_o});

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            left    <= '0;
            idx     <= '0;
            beat    <= '0;
            rd_q    <= 1'b0;
            pipe_d1 <= '0;
            pipe_d2 <= '0;
            wr_id   <= '0;
        end else begin
            rd_q    <= can_read;
            pipe_d1 <= {rd_q && final_w, rd_q && last_w, rd_q};
            pipe_d2 <= pipe_d1;         // match buffer read latency
            if (start_i) begin
                left  <= cfg_i.len;
                idx   <= '0;
                beat  <= '0;
                wr_id <= wr_id + 1'b1;  // tracks the burst generator ID
            end else if (rd_q) begin
                left <= left - membridge_cfg_pkg::addr64_t'(1);
                idx  <= idx + 1'b1;
                beat <= beat + 1'b1;
            end
        end
    end

    assign rd_o         = rd_q;
    assign rd_addr_o    = idx;
    assign afi_wdata_o  = rd_data_i;
    assign afi_wvalid_o = pipe_d2[0];
    assign afi_wlast_o  = pipe_d2[1];
    assign last_word_o  = pipe_d2[2];
    assign afi_wid_o    = wr_id;

endmodule

// File: hdl/membridge_top.sv
`timescale 1ns/10ps

module membridge_top (
    input  logic                          hclk,
    input  logic                          rst,
    input  logic                          reg_we_i,
    input  membridge_cfg_pkg::reg_sel_e   reg_addr_i,
    input  logic [31:0]                   reg_data_i,
    input  logic                          buf_wr_i,
    input  membridge_axi_pkg::wdata_t     buf_wdata_i,
    input  logic                          buf_wpage_nxt_i,
    input  logic                          page_ready_i,
    output membridge_axi_pkg::axi_addr_t  afi_awaddr_o,
    output membridge_axi_pkg::burst_len_t afi_awlen_o,
    output membridge_axi_pkg::axi_id_t    afi_awid_o,
    output logic                          afi_awvalid_o,
    input  logic [5:0]                    afi_wacount_i,
    output membridge_axi_pkg::wdata_t     afi_wdata_o,
    output logic                          afi_wvalid_o,
    output logic                          afi_wlast_o,
    output membridge_axi_pkg::axi_id_t    afi_wid_o,
    input  logic [7:0]                    afi_wcount_i,
    input  logic                          afi_bvalid_i,
    output logic                          next_page_o,
    output logic                          frame_start_o,
    output logic                          busy_o,
    output logic                          done_o
);
    membridge_cfg_pkg::cfg_t    cfg;
    membridge_axi_pkg::aw_req_t aw;
    membridge_axi_pkg::wdata_t  rd_data;
    logic                       start;
    logic [2:0]                 pages_avail;
    logic                       rd;
    logic [6:0]                 rd_addr;
    logic                       page_done;
    logic                       last_word;

    membridge_regs u_regs (
        .hclk, .rst, .reg_we_i, .reg_addr_i, .reg_data_i, .cfg_o(cfg), .start_o(start)
    );

    membridge_page_buf u_page_buf (
        .hclk, .rst, .start_i(start), .buf_wr_i, .buf_wdata_i, .buf_wpage_nxt_i,
        .page_ready_i, .rd_i(rd), .rd_addr_i(rd_addr), .rd_data_o(rd_data),
        .page_done_i(page_done), .pages_avail_o(pages_avail), .next_page_o
    );

    membridge_burst_gen u_burst_gen (
        .hclk, .rst, .cfg_i(cfg), .start_i(start), .afi_wacount_i, .afi_bvalid_i,
        .aw_o(aw), .awvalid_o(afi_awvalid_o), .words_sent_i(last_word), .busy_o, .done_o
    );

    membridge_wdata u_wdata (
        .hclk, .rst, .cfg_i(cfg), .start_i(start), .pages_avail_i(pages_avail),
        .afi_wcount_i, .rd_o(rd), .rd_addr_o(rd_addr), .rd_data_i(rd_data),
        .page_done_o(page_done), .afi_wdata_o, .afi_wvalid_o, .afi_wlast_o, .afi_wid_o,
        .last_word_o(last_word)
    );

    assign afi_awaddr_o  = aw.addr;
    assign afi_awlen_o   = aw.len;
    assign afi_awid_o    = aw.id;
    assign frame_start_o = start;

endmodule

// File: sim/membridge_tb.sv
`timescale 1ns/10ps
`include "membridge_macros.svh"

module membridge_tb;
    typedef membridge_cfg_pkg::addr64_t word_t;

    localparam word_t BURST = word_t'(`MB_BURST_MAX);
    localparam int TOTAL = 40 + 40 + 64 + 32 + 32 + 300;              // words over all transfers
    localparam int LIMIT = (40 * TOTAL > 4000) ? 40 * TOTAL : 4000;   // cycle budget

    logic                          hclk = 1'b0;
    logic                          rst = 1'b1;
    logic                          reg_we_i = 1'b0;
    membridge_cfg_pkg::reg_sel_e   reg_addr_i = membridge_cfg_pkg::REG_CTRL;
    logic [31:0]                   reg_data_i = '0;
    logic                          buf_wr_i = 1'b0;
    membridge_axi_pkg::wdata_t     buf_wdata_i = '0;
    logic                          buf_wpage_nxt_i = 1'b0;
    logic                          page_ready_i = 1'b0;
    logic [5:0]                    afi_wacount_i = '0;
    logic [7:0]                    afi_wcount_i = '0;
    logic                          afi_bvalid_i = 1'b0;
    membridge_axi_pkg::axi_addr_t  afi_awaddr_o;
    membridge_axi_pkg::burst_len_t afi_awlen_o;
    membridge_axi_pkg::axi_id_t    afi_awid_o;
    membridge_axi_pkg::axi_id_t    afi_wid_o;
    membridge_axi_pkg::wdata_t     afi_wdata_o;
    logic                          afi_awvalid_o, afi_wvalid_o, afi_wlast_o;
    logic                          next_page_o, frame_start_o, busy_o, done_o;

    string                         test_name = "reset";
    string                         pend_name = "reset";
    logic [31:0]                   data_rng = 32'h6479_4684;
    logic [31:0]                   fifo_rng = 32'h6479_4684;
    word_t                         pend_lo, pend_size, pend_rel, pend_len;    // next transfer
    word_t                         cur_lo, cur_size, cur_rel, cur_len;        // running transfer
    membridge_axi_pkg::wdata_t     fill_q[$];                                 // words in fill order
    logic [35:0]                   exp_aw;
    logic [5:0]                    wac_prev = '0;
    logic [23:0]                   wc_hist = '0;            // data FIFO levels of the last three cycles
    logic                          hold_aw = 1'b0;
    int cycles = 0, xfer_num = 0, aw_cnt = 0, beat_cnt = 0, resp_cnt = 0, np_cnt = 0;
    int tot_aw = 0, tot_wlast = 0, tot_bsent = 0;

    membridge_top dut (.*);

    always #10 hclk = ~hclk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic int bursts_of(input word_t len);
        return int'((len + BURST - word_t'(1)) / BURST);
    endfunction

    // relative address after n bursts with the wrap to the window base past size
    function automatic word_t rel_after_bursts(input word_t size, input word_t rel0,
                                               input word_t len, input int n);
        word_t rel;
        word_t left;
        int    i;
        rel  = rel0;
        left = len;
        for (i = 0; i < n; i++) begin
            if (left < BURST) begin
                rel  = rel + left;       // partial last burst
                left = '0;
            end else begin
                rel  = (rel + BURST >= size) ? '0 : rel + BURST;
                left = left - BURST;
            end
        end
        return rel;
    endfunction

    // {byte address, awlen} of burst idx
    function automatic logic [35:0] expected_burst(input word_t lo, input word_t size,
                                                   input word_t rel0, input word_t len,
                                                   input int idx);
        word_t rel;
        word_t left;
        rel  = rel_after_bursts(size, rel0, len, idx);
        left = len - word_t'(`MB_BURST_MAX * idx);
        return {lo + rel, 3'b000, (left >= BURST) ? 4'd15 : 4'(left - word_t'(1))};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            fail_run($sformatf("mismatch %s %s: expected %0h, actual %0h",
                               test_name, what, exp, act));
        end
    endtask

    always @(posedge hclk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            fail_run($sformatf("timeout, run not finished after %0d cycles", LIMIT));
        end
    end

    // port model with random FIFO levels and one bvalid per burst that is fully out
    always @(posedge hclk) begin
        fifo_rng = xorshift(fifo_rng);
        afi_wcount_i  <= fifo_rng[7:0] % 8'(`MB_WCOUNT_SAFE + 20);   // sometimes over the mark
        afi_wacount_i <= hold_aw ? 6'(`MB_WACOUNT_SAFE) : 6'(fifo_rng[11:8] % 4'd12);
        if (tot_bsent < ((tot_aw < tot_wlast) ? tot_aw : tot_wlast)) begin
            afi_bvalid_i <= 1'b1;
            tot_bsent++;
        end else begin
            afi_bvalid_i <= 1'b0;
        end
    end

    // compare process
    always @(negedge hclk) begin
        if (!rst) begin
            if (done_o) begin                                        // nothing may be pending
                check_value("responses at done", 64'(bursts_of(cur_len)), 64'(resp_cnt));
                check_value("beats at done", 64'(cur_len), 64'(beat_cnt));
                check_value("busy at done", 64'd0, 64'(busy_o));
            end
            if (frame_start_o) begin
                {cur_lo, cur_size, cur_rel, cur_len} = {pend_lo, pend_size, pend_rel, pend_len};
                test_name = pend_name;
                xfer_num++;                                          // id steps per start
                aw_cnt   = 0;
                beat_cnt = 0;
                resp_cnt = 0;
                np_cnt   = 0;
            end
            if (afi_awvalid_o) begin
                if (wac_prev >= 6'(`MB_WACOUNT_SAFE)) fail_run("burst issued above the FIFO mark");
                exp_aw = expected_burst(cur_lo, cur_size, cur_rel, cur_len, aw_cnt);
                check_value("awaddr", 64'(exp_aw[35:4]), 64'(afi_awaddr_o));
                check_value("awlen", 64'(exp_aw[3:0]), 64'(afi_awlen_o));
                check_value("awid", 64'(xfer_num[5:0]), 64'(afi_awid_o));
                aw_cnt++;
                tot_aw++;
            end
            if (afi_wvalid_o) begin
                if (fill_q.size() == 0) fail_run("write beat with no filled word left");
                if (wc_hist[23:16] >= 8'(`MB_WCOUNT_SAFE)) begin     // level at the read decision
                    fail_run("buffer read started above the data FIFO mark");
                end
                beat_cnt++;
                check_value("wdata", fill_q.pop_front(), afi_wdata_o);
                check_value("wlast", 64'((beat_cnt % `MB_BURST_MAX == 0) ||
                                         (beat_cnt == int'(cur_len))), 64'(afi_wlast_o));
                check_value("wid", 64'(xfer_num[5:0]), 64'(afi_wid_o));
                if (afi_wlast_o) tot_wlast++;
            end
            if (afi_bvalid_i) resp_cnt++;
            if (next_page_o) np_cnt++;
            wac_prev = afi_wacount_i;                                // level seen by next issue
            wc_hist  = {wc_hist[15:0], afi_wcount_i};
        end
    end

    task automatic reg_write(input membridge_cfg_pkg::reg_sel_e addr, input logic [31:0] data);
        @(posedge hclk);
        reg_we_i   <= 1'b1;
        reg_addr_i <= addr;
        reg_data_i <= data;
        @(posedge hclk);
        reg_we_i <= 1'b0;
    endtask

    // fill page by page and mark each one ready once full or at the end
    task automatic fill_pages(input int len);
        membridge_axi_pkg::wdata_t word;
        int                        n;
        n = 0;
        while (n < len) begin
            @(posedge hclk);
            data_rng = xorshift(data_rng);
            word[63:32] = data_rng;
            data_rng = xorshift(data_rng);
            word[31:0] = data_rng;
            buf_wr_i    <= 1'b1;
            buf_wdata_i <= word;
            fill_q.push_back(word);
            n++;
            if ((n % `MB_PAGE_WORDS == 0) || (n == len)) begin
                @(posedge hclk);
                buf_wr_i        <= 1'b0;
                buf_wpage_nxt_i <= 1'b1;
                page_ready_i    <= 1'b1;
                @(posedge hclk);
                buf_wpage_nxt_i <= 1'b0;
                page_ready_i    <= 1'b0;
            end
        end
    endtask

    task automatic run_transfer(input string name, input int lo, input int size, input int start,
                                input int len, input logic cont, input int hold_cycles);
        pend_name = name;
        pend_len  = word_t'(len);
        hold_aw  <= hold_cycles > 0;
        if (cont) begin                                              // address carries on
            {pend_lo, pend_size} = {cur_lo, cur_size};
            pend_rel = rel_after_bursts(cur_size, cur_rel, cur_len, bursts_of(cur_len));
        end else begin
            {pend_lo, pend_size, pend_rel} = {word_t'(lo), word_t'(size), word_t'(start)};
            reg_write(membridge_cfg_pkg::REG_LO_ADDR, 32'(lo));
            reg_write(membridge_cfg_pkg::REG_SIZE, 32'(size));
            reg_write(membridge_cfg_pkg::REG_START, 32'(start));
        end
        reg_write(membridge_cfg_pkg::REG_LEN, 32'(len));
        reg_write(membridge_cfg_pkg::REG_CTRL, cont ? 32'h7 : 32'h3);
        @(negedge hclk);
        while (!frame_start_o) @(negedge hclk);
        @(negedge hclk);
        check_value("busy after start", 64'd1, 64'(busy_o));
        fill_pages(len);
        if (hold_cycles > 0) begin
            repeat (hold_cycles) @(posedge hclk);
            check_value("bursts while held", 64'd0, 64'(aw_cnt));
            hold_aw <= 1'b0;
        end
        @(negedge hclk);
        while (!done_o) @(negedge hclk);
        @(posedge hclk);
        check_value("bursts", 64'(bursts_of(word_t'(len))), 64'(aw_cnt));
        check_value("next_page pulses", 64'((len + `MB_PAGE_WORDS - 1) / `MB_PAGE_WORDS),
                    64'(np_cnt));
        check_value("leftover words", 64'd0, 64'(fill_q.size()));
    endtask

    initial begin
        repeat (8) @(posedge hclk);
        rst <= 1'b0;
        @(negedge hclk);
        check_value("outputs after reset", 64'd0, 64'({afi_awvalid_o, afi_wvalid_o, afi_wlast_o,
                    next_page_o, frame_start_o, busy_o, done_o}));
        run_transfer("single", 'h1000, 'h1000, 0, 40, 1'b0, 0);
        run_transfer("rollover", 'h2000, 'h40, 'h30, 40, 1'b0, 0);
        run_transfer("wacount hold", 'h1000, 'h1000, 'h100, 64, 1'b0, 40);
        run_transfer("reset start", 'h3000, 'h200, 'h20, 32, 1'b0, 0);
        reg_write(membridge_cfg_pkg::REG_CTRL, 32'h0);              // enable low
        repeat (2) @(negedge hclk);
        check_value("done after disable", 64'd0, 64'(done_o));
        run_transfer("continue", 0, 0, 0, 32, 1'b1, 0);
        run_transfer("pages", 'h4000, 'h800, 0, 300, 1'b0, 0);
        $display("sim passed");
        $finish;
    end

endmodule

// File: build.f
+incdir+hdl
hdl/membridge_cfg_pkg.sv
hdl/membridge_axi_pkg.sv
hdl/membridge_regs.sv
hdl/membridge_burst_gen.sv
hdl/membridge_page_buf.sv
hdl/membridge_wdata.sv
hdl/membridge_top.sv
sim/membridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the membridge testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module membridge_tb -f build.f -o membridge_sim
./obj_dir/membridge_sim
